//--- verilog.f
logic/pipePkg.sv
logic/decodeStage.sv
logic/regFile.sv
logic/issueStage.sv
logic/executeStage.sv
logic/commitStage.sv
logic/corePipe.sv
verification/pipeTb.sv

//--- verification/pipeTrace.txt
// columns: group, instruction word, expected rd (00 = no writeback), expected data
// a register is read at least three entries after the entry that writes it
1 4d200093 01 000004d2  // addi x1, x0, 0x4d2
1 0f000113 02 000000f0  // addi x2, x0, 0xf0
1 00500193 03 00000005  // addi x3, x0, 5
1 7ff00313 06 000007ff  // addi x6, x0, 0x7ff
1 00208233 04 000005c2  // add  x4, x1, x2
1 401103b3 07 fffffc1e  // sub  x7, x2, x1
1 0020f433 08 000000d0  // and  x8, x1, x2
1 0020e4b3 09 000004f2  // or   x9, x1, x2
1 0060c533 0a 0000032d  // xor  x10, x1, x6
1 003095b3 0b 00009a40  // sll  x11, x1, x3
1 0033d633 0c 07ffffe0  // srl  x12, x7, x3
1 4033d6b3 0d ffffffe0  // sra  x13, x7, x3
2 80008713 0e fffffcd2  // addi x14, x1, -2048
2 fff14793 0f ffffff0f  // xori x15, x2, -1
2 ff03f813 10 fffffc10  // andi x16, x7, -16
2 80006893 11 fffff800  // ori  x17, x0, -2048
3 00c09913 12 004d2000  // slli x18, x1, 12
3 0047d993 13 0ffffff0  // srli x19, x15, 4
3 40875a13 14 fffffffc  // srai x20, x14, 8
3 41f3da93 15 ffffffff  // srai x21, x7, 31
4 0013ab33 16 00000001  // slt  x22, x7, x1
4 0013bbb3 17 00000000  // sltu x23, x7, x1
4 fff0ac13 18 00000000  // slti x24, x1, -1
4 fff0bc93 19 00000001  // sltiu x25, x1, -1
5 00208033 00 00000000  // add  x0, x1, x2
5 12345d37 00 00000000  // lui  x26, 0x12345 (unsupported)
5 02208db3 00 00000000  // mul  x27, x1, x2 (unsupported)
5 00300d33 1a 00000005  // add  x26, x0, x3
6 00a18e13 1c 0000000f  // addi x28, x3, 10
6 ff618e93 1d fffffffb  // addi x29, x3, -10
6 0060cf33 1e 0000032d  // xor  x30, x1, x6
6 006e0fb3 1f 0000080e  // add  x31, x28, x6
6 401e8e33 1c fffffb29  // sub  x28, x29, x1

//--- verification/pipeTb.sv
module pipeTb;

	localparam int CLK_PERIOD  = 10;
	localparam int BURST_GROUP = 6;		// this group runs with no idle cycles

	logic clk;
	logic nrst;
	logic instrValid;
	logic [31:0] instr;
	logic wbValid;
	logic [pipePkg::REG_AW-1:0] wbAddr;
	logic [31:0] wbData;

	// trace entries in file order
	int trGroup [$];
	logic [31:0] trInstr [$];
	logic [pipePkg::REG_AW-1:0] trRd [$];
	logic [31:0] trData [$];
	bit traceLoaded = 1'b0;

	// writebacks still due, oldest first
	int expGroup [$];
	logic [pipePkg::REG_AW-1:0] expRd [$];
	logic [31:0] expData [$];
	int expEdge [$];				// rising edge that sampled the instruction

	int grpWrites [16];
	int grpDone [16];
	int grpErr [16];
	int cycleCnt = 0;				// rising edges so far
	int checkCount = 0;
	int errorCount = 0;
	logic [31:0] lfsrState = 32'hbb775599;

	corePipe UUT (
		.clk(clk),
		.nrst(nrst),
		.instrValid(instrValid),
		.instr(instr),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycleCnt <= cycleCnt + 1;

	// galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic int randomBits(input int n);
		int v;
		int b;
		v = 0;
		for (b = 0; b < n; b++)
		begin
			v = (v << 1) | int'(lfsrState[0]);
			lfsrState = lfsrNext(lfsrState);
		end
		return v;
	endfunction

	function automatic string groupName(input int grp);
		case (grp)
			1: return "register-register ops";
			2: return "immediate ops";
			3: return "immediate shifts";
			4: return "set-less-than";
			5: return "x0 writes and bubbles";
			6: return "back-to-back issue";
			default: return "unnamed group";
		endcase
	endfunction

	task automatic loadTrace(output bit ok);
		int fd;
		string line;
		logic [31:0] g, w, a, d;
		fd = $fopen("verification/pipeTrace.txt", "r");
		ok = (fd != 0);
		if (ok)
		begin
			while ($fgets(line, fd))
			begin
				if ($sscanf(line, "%h %h %h %h", g, w, a, d) == 4)	// skips comment lines
				begin
					trGroup.push_back(int'(g[3:0]));
					trInstr.push_back(w);
					trRd.push_back(a[pipePkg::REG_AW-1:0]);
					trData.push_back(d);
					if (a[pipePkg::REG_AW-1:0] != '0)
						grpWrites[g[3:0]]++;
				end
			end
			$fclose(fd);
			ok = (trInstr.size() != 0);
		end
	endtask

	// drive one entry per falling edge, then 0..3 idle cycles
	task automatic driveTrace();
		int i;
		int gap;
		for (i = 0; i < trInstr.size(); i++)
		begin
			instrValid = 1'b1;
			instr      = trInstr[i];
			if (trRd[i] != '0)
			begin
				expGroup.push_back(trGroup[i]);
				expRd.push_back(trRd[i]);
				expData.push_back(trData[i]);
				expEdge.push_back(cycleCnt + 1);	// next rising edge samples it
			end
			@(negedge clk);
			instrValid = 1'b0;
			if (trGroup[i] != BURST_GROUP)
			begin
				gap = randomBits(2);
				repeat (gap) @(negedge clk);
			end
		end
	endtask

	// per-group bookkeeping, one line once a group has fully retired
	task automatic finishEntry(input int grp, input int errBefore);
		grpErr[grp] += errorCount - errBefore;
		grpDone[grp]++;
		if (grpDone[grp] == grpWrites[grp])
			$display("group %0d (%s): %0d writebacks, %0d errors",
				grp, groupName(grp), grpDone[grp], grpErr[grp]);
	endtask

	task automatic checkWriteback();
		int grp;
		int sampled;
		int errBefore;
		logic [pipePkg::REG_AW-1:0] rdExp;
		logic [31:0] dataExp;
		errBefore = errorCount;
		assert (expRd.size() != 0)
		else
		begin
			$display("extra writeback to x%0d with no instruction left to retire", wbAddr);
			errorCount++;
		end
		if (expRd.size() != 0)
		begin
			grp     = expGroup.pop_front();
			rdExp   = expRd.pop_front();
			dataExp = expData.pop_front();
			sampled = expEdge.pop_front();
			checkCount++;
			assert (wbAddr === rdExp)
			else
			begin
				$display("mismatch wbAddr: got %h, expected %h", wbAddr, rdExp);
				errorCount++;
			end
			assert (wbData === dataExp)
			else
			begin
				$display("mismatch wbData (x%0d): got %h, expected %h", rdExp, wbData, dataExp);
				errorCount++;
			end
			// strobe is up between edges k+3 and k+4, the write lands on k+4
			assert (cycleCnt == sampled + 3)
			else
			begin
				$display("writeback to x%0d came %0d edges after its instruction, not 4",
					rdExp, cycleCnt - sampled + 1);
				errorCount++;
			end
			finishEntry(grp, errBefore);
		end
	endtask

	// outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk)
	begin
		if (nrst)
		begin
			if (wbValid)
				checkWriteback();
			else if (expRd.size() != 0)
			begin
				assert (cycleCnt <= expEdge[0] + 3)
				else
				begin
					$display("no writeback seen for x%0d in its slot", expRd[0]);
					errorCount++;
					finishEntry(expGroup[0], errorCount - 1);
					void'(expGroup.pop_front());
					void'(expRd.pop_front());
					void'(expData.pop_front());
					void'(expEdge.pop_front());
				end
			end
		end
	end

	initial
	begin
		bit ok;
		nrst       = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		loadTrace(ok);
		traceLoaded = 1'b1;
		if (!ok)
		begin
			$display("could not read any entries from verification/pipeTrace.txt");
			$display("*** TEST FAILED ***");
			$finish;
		end
		else
		begin
			repeat (5) @(negedge clk);	// five cycles in reset
			nrst = 1'b1;
			@(negedge clk);
			driveTrace();
			while (expRd.size() != 0)
				@(negedge clk);
			repeat (4) @(negedge clk);	// catch a stray late strobe
			$display("%0d writebacks checked, %0d errors", checkCount, errorCount);
			if (errorCount == 0)
				$display("*** TEST PASSED ***");
			else
				$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// up to 4 cycles per entry plus reset and drain
	initial
	begin
		wait (traceLoaded);
		#((trInstr.size() * 4 + 20) * CLK_PERIOD);
		$display("timeout: the run did not finish in the expected time");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- logic/corePipe.sv
module corePipe (
	input  logic clk,
	input  logic nrst,
	input  logic instrValid,
	input  logic [31:0] instr,
	output logic wbValid,
	output logic [pipePkg::REG_AW-1:0] wbAddr,
	output logic [31:0] wbData
);

	// decode -> issue
	logic [pipePkg::REG_AW-1:0] rs1, rs2, rd3, shamt;
	logic [11:0] imm;
	pipePkg::bSel_e bSel3;
	pipePkg::aluOp_e aluFn3;
	pipePkg::resSel_e fn3;
	logic we3;

	// issue -> execute
	logic [31:0] opA, opB;
	logic [pipePkg::REG_AW-1:0] rd4;
	pipePkg::aluOp_e aluFn4;
	pipePkg::resSel_e fn4;
	logic we4;

	// execute -> commit
	logic [31:0] aluRes5;
	logic cmpRes5;
	logic [pipePkg::REG_AW-1:0] rd5;
	pipePkg::resSel_e fn5;
	logic we5;

	// commit -> regfile write port and top outputs
	logic we6;
	logic [pipePkg::REG_AW-1:0] rdAddr6;
	logic [31:0] wb6;

	decodeStage dec (.clk(clk), .nrst(nrst), .instrValid(instrValid), .instr(instr),
		.rs1(rs1), .rs2(rs2), .rd3(rd3), .imm(imm), .shamt(shamt),
		.bSel3(bSel3), .aluFn3(aluFn3), .fn3(fn3), .we3(we3));

	issueStage iss (.clk(clk), .nrst(nrst), .we6(we6), .rdAddr6(rdAddr6), .wb6(wb6),
		.rs1(rs1), .rs2(rs2), .rd3(rd3), .shamt(shamt), .imm(imm),
		.bSel3(bSel3), .aluFn3(aluFn3), .fn3(fn3), .we3(we3),
		.opA(opA), .opB(opB), .rd4(rd4), .aluFn4(aluFn4), .fn4(fn4), .we4(we4));

	executeStage exe (.clk(clk), .nrst(nrst), .opA(opA), .opB(opB), .rd4(rd4),
		.aluFn4(aluFn4), .fn4(fn4), .we4(we4),
		.aluRes5(aluRes5), .cmpRes5(cmpRes5), .rd5(rd5), .fn5(fn5), .we5(we5));

	commitStage com (.clk(clk), .nrst(nrst), .aluRes5(aluRes5), .cmpRes5(cmpRes5),
		.rd5(rd5), .fn5(fn5), .we5(we5),
		.we6(we6), .rdAddr6(rdAddr6), .wb6(wb6));

	assign wbValid = we6;	// one-cycle strobe, no stall
	assign wbAddr  = rdAddr6;
	assign wbData  = wb6;

endmodule

//--- logic/commitStage.sv
module commitStage (
	input  logic clk,
	input  logic nrst,
	input  logic [31:0] aluRes5,
	input  logic cmpRes5,
	input  logic [pipePkg::REG_AW-1:0] rd5,
	input  pipePkg::resSel_e fn5,
	input  logic we5,
	output logic we6,					// also the writeback strobe
	output logic [pipePkg::REG_AW-1:0] rdAddr6,
	output logic [31:0] wb6
);

	logic [31:0] result;

	// slt/sltu give 0 or 1
	assign result = (fn5 == pipePkg::resCmp) ? {31'b0, cmpRes5} : aluRes5;

	// pipe #6
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			we6     <= 1'b0;
			rdAddr6 <= '0;
			wb6     <= '0;
		end
		else
		begin
			we6     <= we5;
			rdAddr6 <= rd5;
			wb6     <= result;
		end
	end

	// x0 writes were dropped back in decode
	aNoX0Commit: assert property (@(posedge clk) disable iff (!nrst) we6 |-> (rdAddr6 != '0));

endmodule

//--- logic/executeStage.sv
module executeStage (
	input  logic clk,
	input  logic nrst,
	input  logic [31:0] opA,
	input  logic [31:0] opB,
	input  logic [pipePkg::REG_AW-1:0] rd4,
	input  pipePkg::aluOp_e aluFn4,
	input  pipePkg::resSel_e fn4,
	input  logic we4,
	output logic [31:0] aluRes5,
	output logic cmpRes5,
	output logic [pipePkg::REG_AW-1:0] rd5,
	output pipePkg::resSel_e fn5,
	output logic we5
);

	logic [31:0] aluOut;
	logic [4:0] shAmt;					// shifts use b[4:0] only
	pipePkg::cmpOp_e cmpKind;
	logic lessThan;

	assign shAmt   = opB[4:0];
	assign cmpKind = pipePkg::cmpOp_e'(aluFn4[0]);	// meaningful only for resCmp

	always_comb
	begin
		unique case (aluFn4)
			pipePkg::aluAdd: aluOut = opA + opB;
			pipePkg::aluSub: aluOut = opA - opB;
			pipePkg::aluAnd: aluOut = opA & opB;
			pipePkg::aluOr:  aluOut = opA | opB;
			pipePkg::aluXor: aluOut = opA ^ opB;
			pipePkg::aluSll: aluOut = opA << shAmt;
			pipePkg::aluSrl: aluOut = opA >> shAmt;
			pipePkg::aluSra: aluOut = $unsigned($signed(opA) >>> shAmt);
			default:         aluOut = opA + opB;
		endcase
	end

	// comparator beside the alu
	assign lessThan = (cmpKind == pipePkg::cmpSigned) ? ($signed(opA) < $signed(opB))
		: (opA < opB);

	// pipe #5
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			aluRes5 <= '0;
			cmpRes5 <= 1'b0;
			rd5     <= '0;
			fn5     <= pipePkg::resAlu;
			we5     <= 1'b0;
		end
		else
		begin
			aluRes5 <= aluOut;
			cmpRes5 <= lessThan;
			rd5     <= rd4;
			fn5     <= fn4;
			we5     <= we4;
		end
	end

endmodule

//--- logic/issueStage.sv
module issueStage (
	input  logic clk,
	input  logic nrst,
	input  logic we6,					// write port from commit
	input  logic [pipePkg::REG_AW-1:0] rdAddr6,
	input  logic [31:0] wb6,
	input  logic [pipePkg::REG_AW-1:0] rs1,
	input  logic [pipePkg::REG_AW-1:0] rs2,
	input  logic [pipePkg::REG_AW-1:0] rd3,
	input  logic [pipePkg::REG_AW-1:0] shamt,
	input  logic [11:0] imm,
	input  pipePkg::bSel_e bSel3,
	input  pipePkg::aluOp_e aluFn3,
	input  pipePkg::resSel_e fn3,
	input  logic we3,
	output logic [31:0] opA,
	output logic [31:0] opB,
	output logic [pipePkg::REG_AW-1:0] rd4,
	output pipePkg::aluOp_e aluFn4,
	output pipePkg::resSel_e fn4,
	output logic we4
);

	// pipe #4 fields that only issue needs
	logic [pipePkg::REG_AW-1:0] shamt4;
	logic [11:0] imm4;
	pipePkg::bSel_e bSel4;
	logic [31:0] regB;					// rs2 value

	regFile rf (
		.clk(clk),
		.nrst(nrst),
		.we(we6),
		.writeAddr(rdAddr6),
		.sourceA(rs1),
		.sourceB(rs2),
		.result(wb6),
		.rdA(opA),					// operand A is always rs1
		.rdB(regB)
	);

	// lines up with the registered read inside regFile
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			rd4    <= '0;
			shamt4 <= '0;
			imm4   <= '0;
			bSel4  <= pipePkg::bSelReg;
			aluFn4 <= pipePkg::aluAdd;
			fn4    <= pipePkg::resAlu;
			we4    <= 1'b0;
		end
		else
		begin
			rd4    <= rd3;
			shamt4 <= shamt;
			imm4   <= imm;
			bSel4  <= bSel3;
			aluFn4 <= aluFn3;
			fn4    <= fn3;
			we4    <= we3;
		end
	end

	always_comb
	begin
		unique case (bSel4)
			pipePkg::bSelReg:   opB = regB;
			pipePkg::bSelImm:   opB = {{20{imm4[11]}}, imm4};	// sign-extend
			pipePkg::bSelShamt: opB = {{(32-pipePkg::REG_AW){1'b0}}, shamt4};
			default:            opB = regB;
		endcase
	end

	aBSelLegal: assert property (@(posedge clk) disable iff (!nrst)
		bSel4 inside {pipePkg::bSelReg, pipePkg::bSelImm, pipePkg::bSelShamt});

endmodule

//--- logic/regFile.sv
module regFile (
	input  logic clk,
	input  logic nrst,
	input  logic we,
	input  logic [pipePkg::REG_AW-1:0] writeAddr,
	input  logic [pipePkg::REG_AW-1:0] sourceA,
	input  logic [pipePkg::REG_AW-1:0] sourceB,
	input  logic [31:0] result,				// write data
	output logic [31:0] rdA,
	output logic [31:0] rdB
);

	logic [31:0] regs [1:31];				// x0 has no storage

	// read port with write-through, x0 reads zero
	function automatic logic [31:0] readPort(input logic [pipePkg::REG_AW-1:0] src);
		if (src == '0)
			return '0;
		else if (we && (src == writeAddr))
			return result;
		else
			return regs[src];
	endfunction

	always_ff @(posedge clk)
	begin
		if (we && (writeAddr != '0))
			regs[writeAddr] <= result;
	end

	// synchronous read, part of pipe #4
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			rdA <= '0;
			rdB <= '0;
		end
		else
		begin
			rdA <= readPort(sourceA);
			rdB <= readPort(sourceB);
		end
	end

	// decode filters rd == 0, so commit should never request it
	aWriteNotX0: assert property (@(posedge clk) disable iff (!nrst) we |-> (writeAddr != '0));

endmodule

//--- logic/decodeStage.sv
module decodeStage (
	input  logic clk,
	input  logic nrst,
	input  logic instrValid,				// one-cycle strobe
	input  logic [31:0] instr,
	output logic [pipePkg::REG_AW-1:0] rs1,
	output logic [pipePkg::REG_AW-1:0] rs2,
	output logic [pipePkg::REG_AW-1:0] rd3,
	output logic [11:0] imm,				// raw, extended later in issue
	output logic [pipePkg::REG_AW-1:0] shamt,
	output pipePkg::bSel_e bSel3,
	output pipePkg::aluOp_e aluFn3,
	output pipePkg::resSel_e fn3,
	output logic we3
);

	// instruction fields
	pipePkg::opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [pipePkg::REG_AW-1:0] rdField;

	logic isReg, isImm;
	logic zeroF7, altF7;
	logic legal;						// funct3/funct7 combination is supported
	pipePkg::aluOp_e aluFn;
	pipePkg::resSel_e resSel;
	pipePkg::bSel_e bSel;
	logic writes;

	assign opcode  = pipePkg::opcode_e'(instr[6:0]);
	assign rdField = instr[11:7];
	assign funct3  = instr[14:12];
	assign funct7  = instr[31:25];

	assign isReg  = (opcode == pipePkg::opReg);
	assign isImm  = (opcode == pipePkg::opImm);
	assign zeroF7 = (funct7 == 7'b0);
	assign altF7  = (funct7 == pipePkg::F7_ALT);

	always_comb
	begin
		aluFn  = pipePkg::aluAdd;
		resSel = pipePkg::resAlu;
		bSel   = isImm ? pipePkg::bSelImm : pipePkg::bSelReg;
		legal  = 1'b0;
		case (funct3)
			pipePkg::F3_ADD:
			begin
				aluFn = (isReg && altF7) ? pipePkg::aluSub : pipePkg::aluAdd;
				legal = isImm || zeroF7 || altF7;	// funct7 is imm bits for addi
			end
			pipePkg::F3_SLL:
			begin
				aluFn = pipePkg::aluSll;
				legal = zeroF7;
				if (isImm)
					bSel = pipePkg::bSelShamt;
			end
			pipePkg::F3_SLT:
			begin
				resSel = pipePkg::resCmp;
				aluFn  = pipePkg::aluOp_e'({3'b000, pipePkg::cmpSigned});
				legal  = isImm || zeroF7;
			end
			pipePkg::F3_SLTU:
			begin
				resSel = pipePkg::resCmp;
				aluFn  = pipePkg::aluOp_e'({3'b000, pipePkg::cmpUnsigned});
				legal  = isImm || zeroF7;
			end
			pipePkg::F3_XOR:
			begin
				aluFn = pipePkg::aluXor;
				legal = isImm || zeroF7;
			end
			pipePkg::F3_SR:
			begin
				aluFn = altF7 ? pipePkg::aluSra : pipePkg::aluSrl;
				legal = zeroF7 || altF7;
				if (isImm)
					bSel = pipePkg::bSelShamt;	// srli / srai take shamt
			end
			pipePkg::F3_OR:
			begin
				aluFn = pipePkg::aluOr;
				legal = isImm || zeroF7;
			end
			pipePkg::F3_AND:
			begin
				aluFn = pipePkg::aluAnd;
				legal = isImm || zeroF7;
			end
		endcase
	end

	// anything unsupported or aimed at x0 becomes a bubble
	assign writes = instrValid && (isReg || isImm) && legal && (rdField != '0);

	// pipe #3
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			rs1    <= '0;
			rs2    <= '0;
			rd3    <= '0;
			imm    <= '0;
			shamt  <= '0;
			bSel3  <= pipePkg::bSelReg;
			aluFn3 <= pipePkg::aluAdd;
			fn3    <= pipePkg::resAlu;
			we3    <= 1'b0;
		end
		else
		begin
			rs1    <= instr[19:15];
			rs2    <= instr[24:20];
			rd3    <= rdField;
			imm    <= instr[31:20];
			shamt  <= instr[24:20];		// same bits as rs2
			bSel3  <= bSel;
			aluFn3 <= aluFn;
			fn3    <= resSel;
			we3    <= writes;
		end
	end

endmodule

//--- logic/pipePkg.sv
package pipePkg;

	localparam int REG_AW = 5;	// x0..x31

	// alu function, 4 bits wide
	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,	// low bit also marks an unsigned compare
		aluAnd = 4'd2,
		aluOr  = 4'd3,
		aluXor = 4'd4,
		aluSll = 4'd5,
		aluSrl = 4'd6,
		aluSra = 4'd7
	} aluOp_e;

	// where operand b comes from
	typedef enum logic [1:0] {
		bSelReg   = 2'd0,
		bSelImm   = 2'd1,
		bSelShamt = 2'd2
	} bSel_e;

	typedef enum logic {
		resAlu = 1'b0,
		resCmp = 1'b1
	} resSel_e;

	// compare kind, carried in aluFn[0] when resCmp is selected
	typedef enum logic {
		cmpSigned   = 1'b0,
		cmpUnsigned = 1'b1
	} cmpOp_e;

	typedef enum logic [6:0] {
		opReg = 7'b0110011,	// OP
		opImm = 7'b0010011	// OP-IMM
	} opcode_e;

	// funct3 / funct7 field values
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [6:0] F7_ALT  = 7'b0100000;	// sub / sra

endpackage
